/* logic/cnn_stream_pkg.sv */
//==========================================================================
// stream format shared by the convolution stage and its testbench
// pixel type plus line and frame geometry
//==========================================================================
package cnn_stream_pkg;

    // signed input and output pixels
    localparam int DATA_WIDTH = 8;

    typedef logic signed [DATA_WIDTH-1:0] pixel_t;

    // pixels per line, must stay even for the 2-wide pool
    localparam int LINE_LEN = 8;

    // lines between sof and eof
    localparam int LINES_PER_FRAME = 4;

    // pixel position inside a line
    localparam int PIX_CNT_WIDTH = $clog2(LINE_LEN);

endpackage

/* logic/cnn_layer_pkg.sv */
//==========================================================================
// layer arithmetic for the two convolution branches and the max pool
// weights are fixed constants, ordered current, previous, second previous
//==========================================================================
package cnn_layer_pkg;

    localparam int KERNEL_TAPS  = 3;
    localparam int WEIGHT_WIDTH = 4;

    // smoothing kernel
    localparam logic signed [WEIGHT_WIDTH-1:0] KERNEL_L [KERNEL_TAPS] =
        '{4'sd1, 4'sd2, 4'sd1};

    // edge kernel
    localparam logic signed [WEIGHT_WIDTH-1:0] KERNEL_R [KERNEL_TAPS] =
        '{4'sd2, 4'sd0, -4'sd2};

    // holds 3 x 8-bit x 4-bit products with headroom
    localparam int ACC_WIDTH = 14;

    // arithmetic shift before the ReLU
    localparam int ACC_SHIFT = 2;

    // upper clamp of the ReLU
    localparam int RELU_MAX = 127;

    // horizontal pool window
    localparam int POOL_WIDTH = 2;

endpackage

/* logic/conv_branch.sv */
`timescale 1ns/1ps
//==========================================================================
// one convolution branch: causal 3-tap line filter, shift and ReLU clamp
// output valid and markers two cycles after the input pixel
//==========================================================================
module conv_branch #(
    parameter logic signed [cnn_layer_pkg::WEIGHT_WIDTH-1:0]
        KERNEL [cnn_layer_pkg::KERNEL_TAPS] = cnn_layer_pkg::KERNEL_L
) (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   valid_i,
    input  cnn_stream_pkg::pixel_t data_i,
    input  logic                   sop_i,
    input  logic                   eop_i,
    input  logic                   sof_i,
    input  logic                   eof_i,
    output logic                   valid_o,
    output cnn_stream_pkg::pixel_t data_o,
    output logic                   sop_o,
    output logic                   eop_o,
    output logic                   sof_o,
    output logic                   eof_o
);
    import cnn_stream_pkg::*;
    import cnn_layer_pkg::*;

    pixel_t                      tap_q [KERNEL_TAPS];
    logic                        valid_q;
    // sop, eop, sof, eof of stage one
    logic [3:0]                  mark_q;
    logic signed [ACC_WIDTH-1:0] acc;
    logic signed [ACC_WIDTH-1:0] acc_shr;
    pixel_t                      relu;

    // tap window, older taps start from zero on every line
    always_ff @(posedge clk) begin
        if (valid_i) begin
            tap_q[0] <= data_i;
            for (int i = 1; i < KERNEL_TAPS; i++) begin
                tap_q[i] <= sop_i ? '0 : tap_q[i-1];
            end
        end
    end

    // weighted sum, floor shift, clamp to 0..RELU_MAX
    always_comb begin
        acc = '0;
        for (int i = 0; i < KERNEL_TAPS; i++) begin
            acc = acc + tap_q[i] * KERNEL[i];
        end
        acc_shr = acc >>> ACC_SHIFT;
        if (acc_shr < 0)
            relu = '0;
        else if (acc_shr > RELU_MAX)
            relu = pixel_t'(RELU_MAX);
        else
            relu = pixel_t'(acc_shr);
    end

    always_ff @(posedge clk) begin
        if (valid_q) begin
            data_o <= relu;
        end
    end

    // valid and markers follow the data through both stages
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            mark_q  <= '0;
            valid_o <= 1'b0;
            sop_o   <= 1'b0;
            eop_o   <= 1'b0;
            sof_o   <= 1'b0;
            eof_o   <= 1'b0;
        end else begin
            valid_q <= valid_i;
            mark_q  <= valid_i ? {sop_i, eop_i, sof_i, eof_i} : 4'b0000;
            valid_o <= valid_q;
            sop_o   <= mark_q[3];
            eop_o   <= mark_q[2];
            sof_o   <= mark_q[1];
            eof_o   <= mark_q[0];
        end
    end

endmodule

/* logic/concat_channels.sv */
`timescale 1ns/1ps
//==========================================================================
// joins left and right branch pixels into one two-channel stream
// left word leaves one cycle after input, right word the cycle after
//==========================================================================
module concat_channels (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   valid_i,
    input  cnn_stream_pkg::pixel_t data_l_i,
    input  cnn_stream_pkg::pixel_t data_r_i,
    input  logic                   sop_i,
    input  logic                   eop_i,
    input  logic                   sof_i,
    input  logic                   eof_i,
    output logic                   valid_o,
    output cnn_stream_pkg::pixel_t data_o,
    output logic                   sop_o,
    output logic                   eop_o,
    output logic                   sof_o,
    output logic                   eof_o
);
    import cnn_stream_pkg::*;

    pixel_t right_q;
    logic   right_pend_q;
    logic   eop_q;
    logic   eof_q;

    // right pixel waits one cycle behind the left one
    always_ff @(posedge clk) begin
        if (valid_i) begin
            right_q <= data_r_i;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            data_o <= data_l_i;
        end else if (right_pend_q) begin
            data_o <= right_q;
        end
    end

    // start markers on the left slot, end markers on the right slot
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            right_pend_q <= 1'b0;
            eop_q        <= 1'b0;
            eof_q        <= 1'b0;
            valid_o      <= 1'b0;
            sop_o        <= 1'b0;
            eop_o        <= 1'b0;
            sof_o        <= 1'b0;
            eof_o        <= 1'b0;
        end else begin
            right_pend_q <= valid_i;
            if (valid_i) begin
                eop_q <= eop_i;
                eof_q <= eof_i;
            end
            // input spacing keeps the two slots apart
            valid_o <= valid_i | right_pend_q;
            sop_o   <= valid_i & sop_i;
            sof_o   <= valid_i & sof_i;
            eop_o   <= right_pend_q & eop_q;
            eof_o   <= right_pend_q & eof_q;
        end
    end

endmodule

/* logic/max_pool.sv */
`timescale 1ns/1ps
//==========================================================================
// horizontal max pool over an interleaved left/right two-channel stream
// one output word per channel at the end of each pool window
//==========================================================================
module max_pool (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   valid_i,
    input  cnn_stream_pkg::pixel_t data_i,
    input  logic                   sop_i,
    input  logic                   eop_i,
    input  logic                   sof_i,
    input  logic                   eof_i,
    output logic                   valid_o,
    output cnn_stream_pkg::pixel_t data_o,
    output logic                   sop_o,
    output logic                   eop_o,
    output logic                   sof_o,
    output logic                   eof_o
);
    import cnn_stream_pkg::*;
    import cnn_layer_pkg::*;

    // 0 for left channel, 1 for right
    logic                     slot_q;
    logic [PIX_CNT_WIDTH-1:0] pos_q;
    logic                     sop_pend_q;
    logic                     sof_pend_q;
    pixel_t                   hold_q [2];
    logic                     cur_slot;
    logic [PIX_CNT_WIDTH-1:0] cur_pos;
    logic                     win_first;
    logic                     win_last;
    pixel_t                   win_max;

    // sop restarts slot and position on the current word
    always_comb begin
        cur_slot  = sop_i ? 1'b0 : slot_q;
        cur_pos   = sop_i ? '0 : pos_q;
        win_first = (cur_pos % POOL_WIDTH) == 0;
        win_last  = (cur_pos % POOL_WIDTH) == POOL_WIDTH - 1;
        win_max   = (data_i > hold_q[cur_slot]) ? data_i : hold_q[cur_slot];
    end

    // running max per channel
    always_ff @(posedge clk) begin
        if (valid_i) begin
            hold_q[cur_slot] <= win_first ? data_i : win_max;
            if (win_last) begin
                data_o <= win_max;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            slot_q     <= 1'b0;
            pos_q      <= '0;
            sop_pend_q <= 1'b0;
            sof_pend_q <= 1'b0;
            valid_o    <= 1'b0;
            sop_o      <= 1'b0;
            eop_o      <= 1'b0;
            sof_o      <= 1'b0;
            eof_o      <= 1'b0;
        end else begin
            valid_o <= 1'b0;
            sop_o   <= 1'b0;
            eop_o   <= 1'b0;
            sof_o   <= 1'b0;
            eof_o   <= 1'b0;
            if (valid_i) begin
                slot_q <= ~cur_slot;
                if (cur_slot) begin
                    pos_q <= (cur_pos == PIX_CNT_WIDTH'(LINE_LEN - 1)) ? '0 : cur_pos + 1'b1;
                end
                if (sop_i) begin
                    sop_pend_q <= 1'b1;
                end
                if (sof_i) begin
                    sof_pend_q <= 1'b1;
                end
                if (win_last) begin
                    valid_o <= 1'b1;
                    eop_o   <= eop_i;
                    eof_o   <= eof_i;
                    // start markers move to the first left output of the line
                    if (!cur_slot) begin
                        sop_o      <= sop_pend_q | sop_i;
                        sof_o      <= sof_pend_q | sof_i;
                        sop_pend_q <= 1'b0;
                        sof_pend_q <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

/* logic/conv_nn.sv */
`timescale 1ns/1ps
//==========================================================================
// top of the two-branch convolution stage: branches, concat, max pool
// source must leave at least one idle cycle between input pixels
//==========================================================================
module conv_nn (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   data_valid_i,
    input  cnn_stream_pkg::pixel_t data_l_i,
    input  cnn_stream_pkg::pixel_t data_r_i,
    input  logic                   sop_i,
    input  logic                   eop_i,
    input  logic                   sof_i,
    input  logic                   eof_i,
    output cnn_stream_pkg::pixel_t data_o,
    output logic                   data_valid_o,
    output logic                   sop_o,
    output logic                   eop_o,
    output logic                   sof_o,
    output logic                   eof_o
);
    import cnn_stream_pkg::*;

    logic   br_l_valid;
    pixel_t br_l_data;
    logic   br_l_sop;
    logic   br_l_eop;
    logic   br_l_sof;
    logic   br_l_eof;
    pixel_t br_r_data;

    logic   cat_valid;
    pixel_t cat_data;
    logic   cat_sop;
    logic   cat_eop;
    logic   cat_sof;
    logic   cat_eof;

    conv_branch #(.KERNEL(cnn_layer_pkg::KERNEL_L)) u_branch_l (
        .clk     (clk),          .rst_n_i (rst_n_i),
        .valid_i (data_valid_i), .data_i  (data_l_i),
        .sop_i   (sop_i),        .eop_i   (eop_i),
        .sof_i   (sof_i),        .eof_i   (eof_i),
        .valid_o (br_l_valid),   .data_o  (br_l_data),
        .sop_o   (br_l_sop),     .eop_o   (br_l_eop),
        .sof_o   (br_l_sof),     .eof_o   (br_l_eof)
    );

    // timing matches the left branch, so only its data is taken
    conv_branch #(.KERNEL(cnn_layer_pkg::KERNEL_R)) u_branch_r (
        .clk     (clk),          .rst_n_i (rst_n_i),
        .valid_i (data_valid_i), .data_i  (data_r_i),
        .sop_i   (sop_i),        .eop_i   (eop_i),
        .sof_i   (sof_i),        .eof_i   (eof_i),
        .valid_o (),             .data_o  (br_r_data),
        .sop_o   (),             .eop_o   (),
        .sof_o   (),             .eof_o   ()
    );

    concat_channels u_concat (
        .clk      (clk),        .rst_n_i  (rst_n_i),
        .valid_i  (br_l_valid), .data_l_i (br_l_data), .data_r_i (br_r_data),
        .sop_i    (br_l_sop),   .eop_i    (br_l_eop),
        .sof_i    (br_l_sof),   .eof_i    (br_l_eof),
        .valid_o  (cat_valid),  .data_o   (cat_data),
        .sop_o    (cat_sop),    .eop_o    (cat_eop),
        .sof_o    (cat_sof),    .eof_o    (cat_eof)
    );

    max_pool u_max_pool (
        .clk     (clk),          .rst_n_i (rst_n_i),
        .valid_i (cat_valid),    .data_i  (cat_data),
        .sop_i   (cat_sop),      .eop_i   (cat_eop),
        .sof_i   (cat_sof),      .eof_i   (cat_eof),
        .valid_o (data_valid_o), .data_o  (data_o),
        .sop_o   (sop_o),        .eop_o   (eop_o),
        .sof_o   (sof_o),        .eof_o   (eof_o)
    );

endmodule

/* include/conv_nn_model.svh */
//==========================================================================
// reference model of the convolution stage, included in the testbench
// model_push_line appends one line's expected output words to a queue
//==========================================================================
`ifndef CONV_NN_MODEL_SVH
`define CONV_NN_MODEL_SVH

typedef cnn_stream_pkg::pixel_t model_line_t [cnn_stream_pkg::LINE_LEN];

typedef struct packed {
    cnn_stream_pkg::pixel_t data;
    logic                   sop;
    logic                   eop;
    logic                   sof;
    logic                   eof;
} exp_word_t;

// one branch output at position pos, taps before the line start are zero
function automatic cnn_stream_pkg::pixel_t model_conv(input model_line_t line,
                                                      input int pos, input bit right);
    int acc;
    int tap;
    int w;
    acc = 0;
    for (int k = 0; k < cnn_layer_pkg::KERNEL_TAPS; k++) begin
        tap = (pos - k >= 0) ? int'(line[pos-k]) : 0;
        w   = right ? int'(cnn_layer_pkg::KERNEL_R[k]) : int'(cnn_layer_pkg::KERNEL_L[k]);
        acc = acc + tap * w;
    end
    acc = acc >>> cnn_layer_pkg::ACC_SHIFT;
    if (acc < 0)
        acc = 0;
    if (acc > cnn_layer_pkg::RELU_MAX)
        acc = cnn_layer_pkg::RELU_MAX;
    return cnn_stream_pkg::pixel_t'(acc);
endfunction

// max over pool window j of one channel
function automatic cnn_stream_pkg::pixel_t model_pool(input model_line_t conv, input int j);
    cnn_stream_pkg::pixel_t m;
    m = conv[j*cnn_layer_pkg::POOL_WIDTH];
    for (int k = 1; k < cnn_layer_pkg::POOL_WIDTH; k++) begin
        if (conv[j*cnn_layer_pkg::POOL_WIDTH+k] > m)
            m = conv[j*cnn_layer_pkg::POOL_WIDTH+k];
    end
    return m;
endfunction

// expected words of one input line, left then right per pooled pixel
function automatic void model_push_line(input model_line_t line_l, input model_line_t line_r,
                                        input bit first_line, input bit last_line,
                                        inout exp_word_t exp_q[$]);
    model_line_t conv_l;
    model_line_t conv_r;
    exp_word_t   w;
    int          n_pool;
    n_pool = cnn_stream_pkg::LINE_LEN / cnn_layer_pkg::POOL_WIDTH;
    for (int p = 0; p < cnn_stream_pkg::LINE_LEN; p++) begin
        conv_l[p] = model_conv(line_l, p, 1'b0);
        conv_r[p] = model_conv(line_r, p, 1'b1);
    end
    for (int j = 0; j < n_pool; j++) begin
        for (int ch = 0; ch < 2; ch++) begin
            w      = '0;
            w.data = (ch == 0) ? model_pool(conv_l, j) : model_pool(conv_r, j);
            w.sop  = (j == 0) && (ch == 0);
            w.sof  = w.sop && first_line;
            w.eop  = (j == n_pool - 1) && (ch == 1);
            w.eof  = w.eop && last_line;
            exp_q.push_back(w);
        end
    end
endfunction

`endif

/* testbench/tb_conv_nn.sv */
`timescale 1ns/1ps
//==========================================================================
// testbench for the two-branch convolution stage
// random LCG frames checked word by word against the model
//==========================================================================
module tb_conv_nn;
    import cnn_stream_pkg::*;
    import cnn_layer_pkg::*;

    `include "conv_nn_model.svh"

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 5;
    localparam int IDLE_CHECKS     = 20;
    localparam int TEST_FRAMES     = 7;
    localparam int TOTAL_PIXELS    = TEST_FRAMES * LINE_LEN * LINES_PER_FRAME;
    localparam int WATCHDOG_MARGIN = 200;
    localparam int WATCHDOG_NS     = (TOTAL_PIXELS * 4 + WATCHDOG_MARGIN) * CLK_PERIOD;
    localparam int DRAIN_LIMIT     = 20;

    localparam int MODE_RANDOM  = 0;
    localparam int MODE_EXTREME = 1;
    localparam int MODE_DENSE   = 2;

    localparam pixel_t PIX_MAX = pixel_t'((1 << (DATA_WIDTH - 1)) - 1);
    localparam pixel_t PIX_MIN = pixel_t'(-(1 << (DATA_WIDTH - 1)));

    logic        clk;
    logic        rst_n_i;
    logic        data_valid_i;
    pixel_t      data_l_i;
    pixel_t      data_r_i;
    logic        sop_i;
    logic        eop_i;
    logic        sof_i;
    logic        eof_i;
    pixel_t      data_o;
    logic        data_valid_o;
    logic        sop_o;
    logic        eop_o;
    logic        sof_o;
    logic        eof_o;

    logic [31:0] rng_state = 32'h3338b590;
    int          cyc = 0;
    int          err_cnt = 0;
    int          check_cnt = 0;
    int          test_idx = 0;
    int          test_err_base = 0;
    int          words_in_line = 0;
    int          eop_seen = 0;
    int          sof_seen = 0;
    int          eof_seen = 0;
    int          hi_seen = 0;
    int          zero_seen = 0;
    int          base_eop;
    int          base_sof;
    int          base_eof;
    int          base_hi;
    int          base_zero;
    exp_word_t   exp_q[$];
    // negedge cycle at which each expected word must show up
    int          due_q[$];
    exp_word_t   mon_w;
    int          mon_due;

    conv_nn i_dut (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .data_valid_i (data_valid_i),
        .data_l_i     (data_l_i),
        .data_r_i     (data_r_i),
        .sop_i        (sop_i),
        .eop_i        (eop_i),
        .sof_i        (sof_i),
        .eof_i        (eof_i),
        .data_o       (data_o),
        .data_valid_o (data_valid_o),
        .sop_o        (sop_o),
        .eop_o        (eop_o),
        .sof_o        (sof_o),
        .eof_o        (eof_o)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return {16'h0000, rng_state[31:16]};
    endfunction

    task automatic compare(input string name, input int exp_val, input int act_val);
        check_cnt++;
        if (exp_val != act_val) begin
            err_cnt++;
            $display("Fail at %0d ns: %s expected %0d, got %0d", $time, name, exp_val, act_val);
        end
    endtask

    task automatic report_error(input string msg);
        err_cnt++;
        $display("Error at %0d ns: %s", $time, msg);
    endtask

    task automatic report_test(input string name);
        test_idx++;
        $display("test %0d %s: %0d errors", test_idx, name, err_cnt - test_err_base);
        test_err_base = err_cnt;
    endtask

    task automatic drive_idle();
        data_valid_i = 1'b0;
        data_l_i     = '0;
        data_r_i     = '0;
        sop_i        = 1'b0;
        eop_i        = 1'b0;
        sof_i        = 1'b0;
        eof_i        = 1'b0;
    endtask

    // one pixel pair followed by gap idle cycles
    task automatic drive_pixel(input pixel_t l, input pixel_t r, input logic sop,
                               input logic eop, input logic sof, input logic eof,
                               input bit odd, input int gap);
        @(negedge clk);
        data_valid_i = 1'b1;
        data_l_i     = l;
        data_r_i     = r;
        sop_i        = sop;
        eop_i        = eop;
        sof_i        = sof;
        eof_i        = eof;
        if (odd) begin
            due_q.push_back(cyc + 4);
            due_q.push_back(cyc + 5);
        end
        @(negedge clk);
        drive_idle();
        repeat (gap - 1) @(negedge clk);
    endtask

    task automatic send_frame(input int mode);
        model_line_t line_l;
        model_line_t line_r;
        logic [31:0] r;
        int          gap;
        bit          last;
        for (int ln = 0; ln < LINES_PER_FRAME; ln++) begin
            last = (ln == LINES_PER_FRAME - 1);
            for (int p = 0; p < LINE_LEN; p++) begin
                r = next_rand();
                if (mode == MODE_EXTREME) begin
                    line_l[p] = r[0] ? PIX_MAX : PIX_MIN;
                    line_r[p] = r[1] ? PIX_MAX : PIX_MIN;
                end else begin
                    line_l[p] = pixel_t'(r[7:0]);
                    line_r[p] = pixel_t'(r[15:8]);
                end
            end
            model_push_line(line_l, line_r, ln == 0, last, exp_q);
            for (int p = 0; p < LINE_LEN; p++) begin
                gap = (mode == MODE_DENSE) ? 1 : 1 + int'(next_rand() % 3);
                drive_pixel(line_l[p], line_r[p], p == 0, p == LINE_LEN - 1,
                            ln == 0 && p == 0, last && p == LINE_LEN - 1, p % 2 == 1, gap);
            end
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            report_error($sformatf("%0d expected output words never appeared", exp_q.size()));
            exp_q.delete();
            due_q.delete();
        end
    endtask

    // compare each output word with the next expected one
    always @(negedge clk) begin
        if (rst_n_i && data_valid_o) begin
            if (exp_q.size() == 0 || due_q.size() == 0) begin
                report_error("output word appeared with no expected word pending");
            end else begin
                mon_w   = exp_q.pop_front();
                mon_due = due_q.pop_front();
                compare("data_o", int'(mon_w.data), int'(data_o));
                compare("sop_o", int'(mon_w.sop), int'(sop_o));
                compare("eop_o", int'(mon_w.eop), int'(eop_o));
                compare("sof_o", int'(mon_w.sof), int'(sof_o));
                compare("eof_o", int'(mon_w.eof), int'(eof_o));
                compare("output cycle", mon_due, cyc);
            end
            words_in_line = sop_o ? 1 : words_in_line + 1;
            if (eop_o) begin
                compare("words per line", LINE_LEN, words_in_line);
                eop_seen++;
            end
            if (sof_o)
                sof_seen++;
            if (eof_o)
                eof_seen++;
            if (int'(data_o) == RELU_MAX)
                hi_seen++;
            if (int'(data_o) == 0)
                zero_seen++;
        end
    end

    initial begin
        rst_n_i = 1'b0;
        drive_idle();
        // a line start and its next pixel arrive while reset is held
        for (int i = 0; i < RESET_CYCLES - 1; i++) begin
            @(negedge clk);
            if (i % 2 == 0) begin
                data_valid_i = 1'b1;
                data_l_i     = PIX_MAX;
                data_r_i     = PIX_MAX;
                sop_i        = (i == 0);
                sof_i        = (i == 0);
            end else begin
                drive_idle();
            end
        end
        @(negedge clk);
        drive_idle();
        rst_n_i = 1'b1;

        for (int i = 0; i < IDLE_CHECKS; i++) begin
            @(negedge clk);
            compare("data_valid_o", 0, int'(data_valid_o));
            compare("sop_o", 0, int'(sop_o));
            compare("eop_o", 0, int'(eop_o));
            compare("sof_o", 0, int'(sof_o));
            compare("eof_o", 0, int'(eof_o));
        end
        report_test("idle after reset");

        send_frame(MODE_RANDOM);
        wait_drain();
        report_test("random frame");

        base_hi   = hi_seen;
        base_zero = zero_seen;
        send_frame(MODE_EXTREME);
        wait_drain();
        if (hi_seen == base_hi)
            report_error("no output reached the upper clamp limit");
        if (zero_seen == base_zero)
            report_error("no output was clamped to zero");
        report_test("extreme pixels");

        base_eop = eop_seen;
        base_sof = sof_seen;
        base_eof = eof_seen;
        send_frame(MODE_RANDOM);
        wait_drain();
        compare("eop_o count", LINES_PER_FRAME, eop_seen - base_eop);
        compare("sof_o count", 1, sof_seen - base_sof);
        compare("eof_o count", 1, eof_seen - base_eof);
        report_test("frame markers");

        // minimum input spacing
        send_frame(MODE_DENSE);
        wait_drain();
        report_test("output latency");

        repeat (3) send_frame(MODE_RANDOM);
        wait_drain();
        report_test("back-to-back frames");

        $display("tests %0d, checks %0d, errors %0d", test_idx, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* tb.f */
+incdir+include
logic/cnn_stream_pkg.sv
logic/cnn_layer_pkg.sv
logic/conv_branch.sv
logic/concat_channels.sv
logic/max_pool.sv
logic/conv_nn.sv
testbench/tb_conv_nn.sv

/* run_sim.sh */
#!/bin/sh
# build and run the convolution stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_conv_nn -o sim_tb_conv_nn

out=$(./obj_dir/sim_tb_conv_nn)
echo "$out"

if echo "$out" | grep -q "^STATUS: PASS$"; then
    exit 0
fi
exit 1
